// File: acq_buffer.f
+incdir+tb
src/acq_buf_pkg.sv
src/sample_cntr.sv
src/sample_ram.sv
src/acq_regs.sv
src/acq_wr_ctrl.sv
src/acq_rd_ctrl.sv
src/acq_buffer.sv
tb/tb_acq_buffer.sv

// File: run_sim.sh
#!/bin/sh
# build and run the acq_buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_acq_buffer -f acq_buffer.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_acq_buffer)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the testbench prints the pass line only when every check held
if printf '%s\n' "$out" | grep -q '^TEST PASS$'; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed"
exit 1

// File: src/acq_buf_pkg.sv
`default_nettype none

package acq_buf_pkg;

  // ============================================================
  // widths and identity
  // ============================================================

  localparam int EPOCH_W = 8;

  // read back from word 0
  localparam logic [31:0] ACQ_BUF_ID = 32'hACB0_0100;

  // word offsets from the bus base address
  localparam logic [7:0] REG_ID        = 8'd0;
  localparam logic [7:0] REG_CONTROL   = 8'd1;
  localparam logic [7:0] REG_WR_DEPTH  = 8'd2;
  localparam logic [7:0] REG_RAM_DEPTH = 8'd3;
  localparam logic [7:0] REG_WR_CNTR   = 8'd4;
  localparam logic [7:0] REG_WR_START  = 8'd5;
  localparam logic [7:0] REG_WR_DATA   = 8'd6;

  // ============================================================
  // structs
  // ============================================================

  // one stored sample, sign and magnitude per rail
  typedef struct packed {
    logic q_mag;
    logic q_sig;
    logic i_mag;
    logic i_sig;
  } sample_t;

  // CONTROL register, bit 31 reads back wr_done
  typedef struct packed {
    logic [21:0]        reserved;
    logic [EPOCH_W-1:0] acq_sync_epoch;
    logic               fifo_wr_en;
    logic               acq_sync_en;
  } acq_ctrl_t;

  // single-cycle strobe bus request
  typedef struct packed {
    logic        wr;
    logic        rd;
    logic [7:0]  addr;
    logic [31:0] wdata;
  } reg_bus_req_t;

  // read port command
  typedef struct packed {
    logic        start;
    logic [15:0] start_addr;
    logic [15:0] depth;
  } rd_cmd_t;

endpackage

`default_nettype wire

// File: src/acq_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module acq_buffer #(
  parameter int         DEPTH     = 256,
  parameter logic [7:0] BASE_ADDR = 8'h40
) (
  input  wire                            rf_clk,
  input  wire                            reset,
  input  wire acq_buf_pkg::reg_bus_req_t bus_req,
  output logic [31:0]                    bus_rdata,
  output logic                           bus_rvalid,
  input  wire acq_buf_pkg::sample_t      samp_in,
  input  wire                            we_sum,
  input  wire [acq_buf_pkg::EPOCH_W-1:0] time_epoch,
  input  wire                            wr_clr,
  input  wire                            rd_clr,
  input  wire acq_buf_pkg::rd_cmd_t      rd_cmd,
  output acq_buf_pkg::sample_t           rd_data,
  output logic                           rd_valid,
  output logic                           rd_done,
  output logic                           timegen_wr
);

  import acq_buf_pkg::*;

  localparam int AW = $clog2(DEPTH);

  acq_ctrl_t   ctrl;
  logic [15:0] wr_depth;
  logic [15:0] wr_cntr;
  logic        wr_start;
  logic        wr_data;
  logic        wr_done;
  sample_t     bus_sample;
  sample_t     wr_sample;
  logic        we_ram;
  logic [AW:0] wr_addr;
  logic [AW-1:0] rd_addr;

  // ============================================================
  // control registers
  // ============================================================

  acq_regs #(
    .DEPTH     (DEPTH),
    .BASE_ADDR (BASE_ADDR)
  ) u_acq_regs (
    .rf_clk     (rf_clk),
    .reset      (reset),
    .bus_req    (bus_req),
    .bus_rdata  (bus_rdata),
    .bus_rvalid (bus_rvalid),
    .wr_done    (wr_done),
    .wr_cntr    (wr_cntr),
    .ctrl       (ctrl),
    .wr_depth   (wr_depth),
    .wr_start   (wr_start),
    .wr_data    (wr_data),
    .bus_sample (bus_sample)
  );

  // ============================================================
  // capture side
  // ============================================================

  acq_wr_ctrl #(
    .DEPTH (DEPTH)
  ) u_acq_wr_ctrl (
    .rf_clk     (rf_clk),
    .reset      (reset),
    .wr_clr     (wr_clr),
    .ctrl       (ctrl),
    .wr_depth   (wr_depth),
    .wr_start   (wr_start),
    .wr_data    (wr_data),
    .bus_sample (bus_sample),
    .samp_in    (samp_in),
    .we_sum     (we_sum),
    .time_epoch (time_epoch),
    .we_ram     (we_ram),
    .wr_addr    (wr_addr),
    .wr_sample  (wr_sample),
    .wr_done    (wr_done),
    .wr_cntr    (wr_cntr),
    .timegen_wr (timegen_wr)
  );

  sample_ram #(
    .DEPTH (DEPTH)
  ) u_sample_ram (
    .rf_clk    (rf_clk),
    .we        (we_ram),
    .wr_addr   (wr_addr),
    .wr_sample (wr_sample),
    .rd_addr   (rd_addr),
    .rd_sample (rd_data)
  );

  // ============================================================
  // replay side
  // ============================================================

  acq_rd_ctrl #(
    .DEPTH (DEPTH)
  ) u_acq_rd_ctrl (
    .rf_clk   (rf_clk),
    .reset    (reset),
    .rd_clr   (rd_clr),
    .rd_cmd   (rd_cmd),
    .rd_addr  (rd_addr),
    .rd_valid (rd_valid),
    .rd_done  (rd_done)
  );

endmodule

`default_nettype wire

// File: src/acq_rd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module acq_rd_ctrl #(
  parameter int DEPTH = 256
) (
  input  wire                          rf_clk,
  input  wire                          reset,
  input  wire                          rd_clr,
  input  wire acq_buf_pkg::rd_cmd_t    rd_cmd,
  output logic [$clog2(DEPTH)-1:0]     rd_addr,
  output logic                         rd_valid,
  output logic                         rd_done
);

  localparam int AW = $clog2(DEPTH);

  logic        busy;
  logic        accept;
  logic        re_ram;
  logic [15:0] start_q;
  logic [15:0] depth_q;
  logic [15:0] rd_cntr;
  logic [15:0] addr_sum;

  // ============================================================
  // command latch
  // ============================================================

  // a start while busy is dropped
  assign accept = rd_cmd.start && !busy;

  always_ff @(posedge rf_clk) begin
    if (reset || rd_clr) begin
      busy    <= 1'b0;
      depth_q <= '0;
    end else if (accept) begin
      busy    <= 1'b1;
      depth_q <= rd_cmd.depth;
    end else if (rd_done) begin
      busy    <= 1'b0;
    end
  end

  always_ff @(posedge rf_clk) begin
    if (accept) begin
      start_q <= rd_cmd.start_addr;
    end
  end

  // address wraps modulo DEPTH
  assign addr_sum = start_q + rd_cntr;
  assign rd_addr  = addr_sum[AW-1:0];
  assign re_ram   = busy && !rd_done;

  sample_cntr #(
    .WIDTH (16)
  ) u_rd_cntr (
    .rf_clk   (rf_clk),
    .reset    (reset),
    .clear    (rd_clr || accept),
    .inc      (re_ram),
    .limit    (depth_q),
    .count    (rd_cntr),
    .at_limit (rd_done)
  );

  // valid lines up with the registered RAM output
  always_ff @(posedge rf_clk) begin
    if (reset || rd_clr) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= re_ram;
    end
  end

  a_no_valid_after_reset: assert property (@(posedge rf_clk) reset |=> !rd_valid)
    else $error("rd_valid high right after reset");

endmodule

`default_nettype wire

// File: src/acq_regs.sv
`timescale 1ns/1ps
`default_nettype none

module acq_regs #(
  parameter int         DEPTH     = 256,
  parameter logic [7:0] BASE_ADDR = 8'h40
) (
  input  wire                        rf_clk,
  input  wire                        reset,
  input  wire acq_buf_pkg::reg_bus_req_t bus_req,
  output logic [31:0]                bus_rdata,
  output logic                       bus_rvalid,
  input  wire                        wr_done,
  input  wire [15:0]                 wr_cntr,
  output acq_buf_pkg::acq_ctrl_t     ctrl,
  output logic [15:0]                wr_depth,
  output logic                       wr_start,
  output logic                       wr_data,
  output acq_buf_pkg::sample_t       bus_sample
);

  import acq_buf_pkg::*;

  logic [7:0]  offset;
  acq_ctrl_t   ctrl_wdata;
  logic [31:0] rdata_mux;

  // addresses below the base wrap to large offsets and stay unmapped
  assign offset = bus_req.addr - BASE_ADDR;

  always_comb begin
    ctrl_wdata = acq_ctrl_t'(bus_req.wdata);
    ctrl_wdata.reserved = '0;
  end

  // ============================================================
  // writes
  // ============================================================

  always_ff @(posedge rf_clk) begin
    if (reset) begin
      ctrl     <= '0;
      wr_depth <= '0;
    end else if (bus_req.wr) begin
      if (offset == REG_CONTROL) begin
        ctrl <= ctrl_wdata;
      end
      if (offset == REG_WR_DEPTH) begin
        wr_depth <= bus_req.wdata[15:0];
      end
    end
  end

  // command pulses, one cycle after the write
  always_ff @(posedge rf_clk) begin
    if (reset) begin
      wr_start <= 1'b0;
      wr_data  <= 1'b0;
    end else begin
      wr_start <= bus_req.wr && (offset == REG_WR_START);
      wr_data  <= bus_req.wr && (offset == REG_WR_DATA);
    end
  end

  // test sample travels with the wr_data pulse
  always_ff @(posedge rf_clk) begin
    if (bus_req.wr && (offset == REG_WR_DATA)) begin
      bus_sample <= sample_t'(bus_req.wdata[3:0]);
    end
  end

  // ============================================================
  // reads
  // ============================================================

  always_comb begin
    case (offset)
      REG_ID:        rdata_mux = ACQ_BUF_ID;
      REG_CONTROL:   rdata_mux = {wr_done, ctrl[30:0]};
      REG_WR_DEPTH:  rdata_mux = {16'd0, wr_depth};
      REG_RAM_DEPTH: rdata_mux = 32'(DEPTH);
      REG_WR_CNTR:   rdata_mux = {16'd0, wr_cntr};
      default:       rdata_mux = '0;
    endcase
  end

  always_ff @(posedge rf_clk) begin
    if (bus_req.rd) begin
      bus_rdata <= rdata_mux;
    end
  end

  always_ff @(posedge rf_clk) begin
    if (reset) begin
      bus_rvalid <= 1'b0;
    end else begin
      bus_rvalid <= bus_req.rd;
    end
  end

  a_pulses_exclusive: assert property (@(posedge rf_clk) disable iff (reset)
    !(wr_start && wr_data))
    else $error("wr_start and wr_data pulsed together");

endmodule

`default_nettype wire

// File: src/acq_wr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module acq_wr_ctrl #(
  parameter int DEPTH = 256
) (
  input  wire                              rf_clk,
  input  wire                              reset,
  input  wire                              wr_clr,
  input  wire acq_buf_pkg::acq_ctrl_t      ctrl,
  input  wire [15:0]                       wr_depth,
  input  wire                              wr_start,
  input  wire                              wr_data,
  input  wire acq_buf_pkg::sample_t        bus_sample,
  input  wire acq_buf_pkg::sample_t        samp_in,
  input  wire                              we_sum,
  input  wire [acq_buf_pkg::EPOCH_W-1:0]   time_epoch,
  output logic                             we_ram,
  output logic [$clog2(DEPTH):0]           wr_addr,
  output acq_buf_pkg::sample_t             wr_sample,
  output logic                             wr_done,
  output logic [15:0]                      wr_cntr,
  output logic                             timegen_wr
);

  localparam int AW = $clog2(DEPTH);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ARM,
    ST_CAPTURE,
    ST_DONE
  } wr_state_t;

  wr_state_t   state;
  wr_state_t   state_next;
  logic [15:0] limit;
  logic        strobe;
  logic        sync_ok;
  logic        at_limit;
  logic        last_wr;

  // capture never runs past the end of the RAM
  assign limit = (wr_depth > 16'(DEPTH)) ? 16'(DEPTH) : wr_depth;

  // ============================================================
  // source select and write gating
  // ============================================================

  assign strobe    = ctrl.fifo_wr_en ? wr_data : we_sum;
  assign wr_sample = ctrl.fifo_wr_en ? bus_sample : samp_in;
  assign sync_ok   = !ctrl.acq_sync_en || (time_epoch == ctrl.acq_sync_epoch);

  assign we_ram  = (state == ST_CAPTURE) && strobe && !at_limit;
  assign last_wr = we_ram && (wr_cntr == limit - 16'd1);
  assign wr_addr = wr_cntr[AW:0];
  assign wr_done = (state == ST_DONE);

  // count is zero only for the first stored sample
  assign timegen_wr = we_ram && (wr_cntr == '0);

  always_comb begin
    state_next = state;
    case (state)
      ST_ARM: begin
        if (sync_ok) begin
          state_next = ST_CAPTURE;
        end
      end
      // done rises on the edge that stores the last sample
      ST_CAPTURE: begin
        if (at_limit || last_wr) begin
          state_next = ST_DONE;
        end
      end
      default: begin
      end
    endcase
    if (wr_start) begin
      state_next = ST_ARM;
    end
  end

  always_ff @(posedge rf_clk) begin
    if (reset || wr_clr) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  sample_cntr #(
    .WIDTH (16)
  ) u_wr_cntr (
    .rf_clk   (rf_clk),
    .reset    (reset),
    .clear    (wr_clr || wr_start),
    .inc      (we_ram),
    .limit    (limit),
    .count    (wr_cntr),
    .at_limit (at_limit)
  );

  a_no_write_done: assert property (@(posedge rf_clk) disable iff (reset)
    (state == ST_DONE) |-> !we_ram)
    else $error("RAM write after capture done");

endmodule

`default_nettype wire

// File: src/sample_cntr.sv
`timescale 1ns/1ps
`default_nettype none

module sample_cntr #(
  parameter int WIDTH = 16
) (
  input  wire              rf_clk,
  input  wire              reset,
  input  wire              clear,
  input  wire              inc,
  input  wire [WIDTH-1:0]  limit,
  output logic [WIDTH-1:0] count,
  output logic             at_limit
);

  // ============================================================
  // count register
  // ============================================================

  // clear wins over inc
  always_ff @(posedge rf_clk) begin
    if (reset || clear) begin
      count <= '0;
    end else if (inc) begin
      count <= count + 1'b1;
    end
  end

  // stays high until the next clear
  assign at_limit = (count == limit);

  // users gate inc with at_limit, so the count never overshoots
  a_no_inc_at_limit: assert property (@(posedge rf_clk) disable iff (reset)
    inc |-> !at_limit)
    else $error("counter stepped past its limit");

endmodule

`default_nettype wire

// File: src/sample_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sample_ram #(
  parameter int DEPTH = 256
) (
  input  wire                        rf_clk,
  input  wire                        we,
  input  wire [$clog2(DEPTH):0]      wr_addr,
  input  wire acq_buf_pkg::sample_t  wr_sample,
  input  wire [$clog2(DEPTH)-1:0]    rd_addr,
  output acq_buf_pkg::sample_t       rd_sample
);

  import acq_buf_pkg::*;

  localparam int AW = $clog2(DEPTH);

  sample_t mem [DEPTH];

  // write address keeps the count's extra bit
  always_ff @(posedge rf_clk) begin
    if (we) begin
      mem[wr_addr[AW-1:0]] <= wr_sample;
    end
  end

  // registered read, data one cycle after the address
  always_ff @(posedge rf_clk) begin
    rd_sample <= mem[rd_addr];
  end

  a_wr_in_range: assert property (@(posedge rf_clk) we |-> (wr_addr < DEPTH))
    else $error("sample RAM write beyond DEPTH");

endmodule

`default_nettype wire

// File: tb/acq_buffer_checks.svh
`ifndef ACQ_BUFFER_CHECKS_SVH
`define ACQ_BUFFER_CHECKS_SVH

// ============================================================
// reference model
// ============================================================

// mirror of the sample RAM, filled as stimulus is driven
sample_t model [DEPTH];
integer  seed = 32'h2ef7d98d;

function automatic sample_t random_sample();
  logic [31:0] r;
  r = $random(seed);
  return sample_t'(r[3:0]);
endfunction

// ============================================================
// bus access
// ============================================================

task automatic bus_write(input logic [7:0] offset, input logic [31:0] data);
  @(negedge rf_clk);
  bus_req.wr    = 1'b1;
  bus_req.rd    = 1'b0;
  bus_req.addr  = BASE_ADDR + offset;
  bus_req.wdata = data;
  @(negedge rf_clk);
  bus_req = '0;
endtask

task automatic bus_read(input logic [7:0] offset, output logic [31:0] data);
  int waited;
  waited = 0;
  @(negedge rf_clk);
  bus_req.wr   = 1'b0;
  bus_req.rd   = 1'b1;
  bus_req.addr = BASE_ADDR + offset;
  @(negedge rf_clk);
  bus_req = '0;
  while (!bus_rvalid && waited < TIMEOUT) begin
    @(negedge rf_clk);
    waited++;
  end
  if (!bus_rvalid) begin
    $display("bus read at offset %0d got no rvalid within %0d cycles", offset, TIMEOUT);
    errors++;
    data = '0;
  end else begin
    data = bus_rdata;
  end
endtask

// ============================================================
// compare tasks
// ============================================================

task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
  if (got !== exp) begin
    $display("Error %0t: %s read %h, expected %h", $time, what, got, exp);
    errors++;
  end
endtask

task automatic check_sample(input sample_t got, input sample_t exp, input string what);
  if (got !== exp) begin
    $display("Error %0t: %s sample %h, expected %h", $time, what, got, exp);
    errors++;
  end
endtask

`endif

// File: tb/tb_acq_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_acq_buffer;

  import acq_buf_pkg::*;

  localparam int         DEPTH     = 256;
  localparam logic [7:0] BASE_ADDR = 8'h40;
  localparam int         TIMEOUT   = 4000;
  localparam int         CAP_N     = 40;

  logic               rf_clk;
  logic               reset;
  reg_bus_req_t       bus_req;
  logic [31:0]        bus_rdata;
  logic               bus_rvalid;
  sample_t            samp_in;
  logic               we_sum;
  logic [EPOCH_W-1:0] time_epoch;
  logic               wr_clr;
  logic               rd_clr;
  rd_cmd_t            rd_cmd;
  sample_t            rd_data;
  logic               rd_valid;
  logic               rd_done;
  logic               timegen_wr;

  int      errors;
  int      tests_run;
  int      tests_failed;
  int      cycle_cnt;
  int      tg_count;
  int      tg_cycle;
  int      first_strobe;
  sample_t rd_q [$];
  int      rd_cyc_q [$];

  `include "acq_buffer_checks.svh"

  acq_buffer #(
    .DEPTH     (DEPTH),
    .BASE_ADDR (BASE_ADDR)
  ) u_acq_buffer (
    .rf_clk     (rf_clk),
    .reset      (reset),
    .bus_req    (bus_req),
    .bus_rdata  (bus_rdata),
    .bus_rvalid (bus_rvalid),
    .samp_in    (samp_in),
    .we_sum     (we_sum),
    .time_epoch (time_epoch),
    .wr_clr     (wr_clr),
    .rd_clr     (rd_clr),
    .rd_cmd     (rd_cmd),
    .rd_data    (rd_data),
    .rd_valid   (rd_valid),
    .rd_done    (rd_done),
    .timegen_wr (timegen_wr)
  );

  initial begin
    rf_clk = 1'b0;
    forever #5 rf_clk = ~rf_clk;
  end

  // outputs seen just before each rising edge
  always @(posedge rf_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (timegen_wr) begin
      tg_count = tg_count + 1;
      tg_cycle = cycle_cnt;
    end
    if (rd_valid) begin
      rd_q.push_back(rd_data);
      rd_cyc_q.push_back(cycle_cnt);
    end
  end

  // ============================================================
  // stimulus helpers
  // ============================================================

  task automatic drive_live(input int count, input int first_idx, input bit record);
    sample_t s;
    int      gap;
    for (int i = 0; i < count; i++) begin
      s = random_sample();
      @(negedge rf_clk);
      samp_in = s;
      we_sum  = 1'b1;
      if (record) begin
        model[(first_idx + i) % DEPTH] = s;
      end
      if (i == 0) begin
        first_strobe = cycle_cnt + 1;
      end
      @(negedge rf_clk);
      we_sum = 1'b0;
      // zero to two idle cycles
      gap = $unsigned($random(seed)) % 3;
      repeat (gap) @(negedge rf_clk);
    end
  endtask

  task automatic start_capture(input logic [15:0] depth, input acq_ctrl_t ctrl);
    bus_write(REG_WR_DEPTH, 32'(depth));
    bus_write(REG_CONTROL, 32'(ctrl));
    tg_count = 0;
    bus_write(REG_WR_START, 32'd0);
    // wr_start pulse, then ARM, then CAPTURE
    repeat (2) @(negedge rf_clk);
  endtask

  task automatic wait_wr_done();
    logic [31:0] word;
    int          polls;
    polls = 0;
    word  = '0;
    while (!word[31] && polls < TIMEOUT) begin
      bus_read(REG_CONTROL, word);
      polls++;
    end
    if (!word[31]) begin
      $display("capture did not finish within %0d control polls", TIMEOUT);
      errors++;
    end
  endtask

  task automatic issue_read(input logic [15:0] start, input logic [15:0] depth);
    rd_q.delete();
    rd_cyc_q.delete();
    @(negedge rf_clk);
    rd_cmd.start      = 1'b1;
    rd_cmd.start_addr = start;
    rd_cmd.depth      = depth;
    @(negedge rf_clk);
    rd_cmd.start = 1'b0;
  endtask

  task automatic check_read(input int start, input int count);
    int waited;
    waited = 0;
    while (rd_q.size() < count && waited < TIMEOUT) begin
      @(negedge rf_clk);
      waited++;
    end
    if (rd_q.size() < count) begin
      $display("read stream stopped after %0d of %0d samples", rd_q.size(), count);
      errors++;
    end
    // extra cycles catch any surplus valid
    repeat (4) @(negedge rf_clk);
    check_word(32'(rd_q.size()), 32'(count), "rd_valid count");
    for (int i = 0; i < count && i < rd_q.size(); i++) begin
      check_sample(rd_q[i], model[(start + i) % DEPTH], "rd_data");
      check_word(32'(rd_cyc_q[i] - rd_cyc_q[0]), 32'(i), "rd_valid spacing");
    end
    check_word(32'(rd_done), 32'd1, "rd_done after read");
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s passed", name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, errors - errors_before);
    end
  endtask

  // ============================================================
  // directed tests
  // ============================================================

  task automatic test_register_map();
    int          err0;
    logic [31:0] word;
    acq_ctrl_t   ctrl;
    err0 = errors;
    bus_read(REG_ID, word);
    check_word(word, ACQ_BUF_ID, "ID");
    bus_read(REG_RAM_DEPTH, word);
    check_word(word, 32'(DEPTH), "RAM_DEPTH");
    bus_read(REG_WR_CNTR, word);
    check_word(word, 32'd0, "WR_CNTR after reset");
    bus_read(REG_CONTROL, word);
    check_word(32'(word[31]), 32'd0, "CONTROL done bit after reset");
    bus_read(8'd9, word);
    check_word(word, 32'd0, "unmapped offset");
    bus_write(REG_WR_DEPTH, 32'h0000_0123);
    bus_read(REG_WR_DEPTH, word);
    check_word(word, 32'h0000_0123, "WR_DEPTH");
    ctrl = '0;
    ctrl.acq_sync_en    = 1'b1;
    ctrl.acq_sync_epoch = 8'h5a;
    bus_write(REG_CONTROL, 32'(ctrl));
    bus_read(REG_CONTROL, word);
    check_word(word, 32'(ctrl), "CONTROL");
    bus_write(REG_CONTROL, 32'd0);
    finish_test("register map", err0);
  endtask

  task automatic test_free_capture();
    int          err0;
    logic [31:0] word;
    err0 = errors;
    start_capture(16'(CAP_N), acq_ctrl_t'(32'd0));
    drive_live(CAP_N, 0, 1'b1);
    wait_wr_done();
    check_word(32'(tg_cycle), 32'(first_strobe), "timegen_wr cycle");
    bus_read(REG_WR_CNTR, word);
    check_word(word, 32'(CAP_N), "WR_CNTR at done");
    drive_live(5, 0, 1'b0);
    bus_read(REG_WR_CNTR, word);
    check_word(word, 32'(CAP_N), "WR_CNTR after extra strobes");
    check_word(32'(tg_count), 32'd1, "timegen_wr pulse count");
    finish_test("free-running capture", err0);
  endtask

  task automatic test_read_back();
    int err0;
    err0 = errors;
    issue_read(16'd0, 16'(CAP_N));
    check_read(0, CAP_N);
    issue_read(16'd0, 16'd0);
    check_read(0, 0);
    finish_test("read-back", err0);
  endtask

  task automatic test_epoch_start();
    int          err0;
    logic [31:0] word;
    acq_ctrl_t   ctrl;
    err0 = errors;
    time_epoch = 8'h34;
    ctrl = '0;
    ctrl.acq_sync_en    = 1'b1;
    ctrl.acq_sync_epoch = 8'h37;
    start_capture(16'd24, ctrl);
    drive_live(6, 0, 1'b0);
    bus_read(REG_WR_CNTR, word);
    check_word(word, 32'd0, "WR_CNTR before epoch");
    check_word(32'(tg_count), 32'd0, "timegen_wr before epoch");
    @(negedge rf_clk);
    time_epoch = 8'h37;
    drive_live(24, 0, 1'b1);
    wait_wr_done();
    check_word(32'(tg_cycle), 32'(first_strobe), "timegen_wr cycle");
    check_word(32'(tg_count), 32'd1, "timegen_wr pulse count");
    bus_read(REG_WR_CNTR, word);
    check_word(word, 32'd24, "WR_CNTR at done");
    issue_read(16'd0, 16'd24);
    check_read(0, 24);
    finish_test("epoch-synchronized start", err0);
  endtask

  task automatic test_bus_data();
    int          err0;
    logic [31:0] word;
    acq_ctrl_t   ctrl;
    err0 = errors;
    ctrl = '0;
    ctrl.fifo_wr_en = 1'b1;
    start_capture(16'(DEPTH), ctrl);
    // live strobes stay high and must be ignored
    we_sum = 1'b1;
    for (int i = 0; i < DEPTH; i++) begin
      word     = $random(seed);
      model[i] = sample_t'(word[3:0]);
      samp_in  = ~model[i];
      bus_write(REG_WR_DATA, word);
    end
    wait_wr_done();
    we_sum = 1'b0;
    bus_read(REG_WR_CNTR, word);
    check_word(word, 32'(DEPTH), "WR_CNTR after bus data");
    bus_write(REG_CONTROL, 32'd0);
    issue_read(16'd200, 16'd120);
    check_read(200, 120);
    finish_test("bus test data", err0);
  endtask

  task automatic test_clears();
    int          err0;
    int          waited;
    int          seen;
    logic [31:0] word;
    err0   = errors;
    waited = 0;
    start_capture(16'd30, acq_ctrl_t'(32'd0));
    drive_live(10, 0, 1'b1);
    @(negedge rf_clk);
    wr_clr = 1'b1;
    @(negedge rf_clk);
    wr_clr = 1'b0;
    bus_read(REG_WR_CNTR, word);
    check_word(word, 32'd0, "WR_CNTR after wr_clr");
    bus_read(REG_CONTROL, word);
    check_word(32'(word[31]), 32'd0, "CONTROL done bit after wr_clr");
    drive_live(3, 0, 1'b0);
    bus_read(REG_WR_CNTR, word);
    check_word(word, 32'd0, "WR_CNTR idle after wr_clr");

    issue_read(16'd0, 16'd100);
    while (rd_q.size() < 10 && waited < TIMEOUT) begin
      @(negedge rf_clk);
      waited++;
    end
    if (rd_q.size() < 10) begin
      $display("read stream did not start before rd_clr");
      errors++;
    end
    rd_clr = 1'b1;
    seen   = rd_q.size();
    @(negedge rf_clk);
    rd_clr = 1'b0;
    check_word(32'(rd_valid), 32'd0, "rd_valid after rd_clr");
    check_word(32'(rd_done), 32'd1, "rd_done after rd_clr");
    repeat (4) @(negedge rf_clk);
    check_word(32'(rd_q.size()), 32'(seen + 1), "samples after rd_clr");
    for (int i = 0; i < rd_q.size(); i++) begin
      check_sample(rd_q[i], model[i], "rd_data before rd_clr");
    end
    finish_test("clears", err0);
  endtask

  // ============================================================
  // main sequence
  // ============================================================

  initial begin
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    cycle_cnt    = 0;
    tg_count     = 0;
    tg_cycle     = 0;
    first_strobe = 0;
    reset        = 1'b1;
    bus_req      = '0;
    samp_in      = '0;
    we_sum       = 1'b0;
    time_epoch   = '0;
    wr_clr       = 1'b0;
    rd_clr       = 1'b0;
    rd_cmd       = '0;
    repeat (10) @(posedge rf_clk);
    @(negedge rf_clk);
    reset = 1'b0;

    test_register_map();
    test_free_capture();
    test_read_back();
    test_epoch_start();
    test_bus_data();
    test_clears();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
